// File: rt_consts.svh
`ifndef RT_CONSTS_SVH
`define RT_CONSTS_SVH

// Frame size in pixels
`define RT_COLS 8
`define RT_ROWS 6
`define RT_NUM_RAYS (`RT_COLS * `RT_ROWS)

// Fixed-point vector component width
`define RT_VW 16

`define RT_FIFO_DEPTH 8
`define RT_PIPE_LAT 3

// APB register map, components x/y/z at +0/+4/+8
`define RT_ADDR_CTRL 8'h00
`define RT_ADDR_E 8'h10
`define RT_ADDR_U 8'h20
`define RT_ADDR_V 8'h30
`define RT_ADDR_W 8'h40

`endif

// File: rt_pkg.sv
`include "rt_consts.svh"

package rt_pkg;

	typedef struct packed {
		logic signed [`RT_VW-1:0] x;
		logic signed [`RT_VW-1:0] y;
		logic signed [`RT_VW-1:0] z;
	} vec_t;

	// Eye point and camera basis
	typedef struct packed {
		vec_t e;
		vec_t u;
		vec_t v;
		vec_t w;
	} cam_t;

	typedef logic [$clog2(`RT_NUM_RAYS)-1:0] pixel_id_t;
	typedef logic [$clog2(`RT_COLS)-1:0] col_t;
	typedef logic [$clog2(`RT_ROWS)-1:0] row_t;

	typedef struct packed {
		col_t x;
		row_t y;
		pixel_id_t id;
	} pix_t;

	typedef struct packed {
		vec_t origin;
		vec_t dir;
		pixel_id_t id;
	} ray_t;

endpackage

// File: cam_regs.sv
`timescale 1ns/1ns
`include "rt_consts.svh"

module cam_regs (
	input logic clk,
	input logic rst,
	input logic [7:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic busy,
	output rt_pkg::cam_t cam,
	output logic start
);

	function automatic logic [`RT_VW-1:0] get_comp(rt_pkg::vec_t v, logic [1:0] c);
		case (c)
			2'd0: return v.x;
			2'd1: return v.y;
			default: return v.z;
		endcase
	endfunction

	function automatic rt_pkg::vec_t set_comp(rt_pkg::vec_t v, logic [1:0] c,
			logic [`RT_VW-1:0] d);
		rt_pkg::vec_t r;
		r = v;
		case (c)
			2'd0: r.x = d;
			2'd1: r.y = d;
			default: r.z = d;
		endcase
		return r;
	endfunction

	logic acc, wr_ok, mapped;
	logic [7:0] base;
	logic [1:0] comp;
	logic comp_ok;
	logic hit_ctrl, hit_e, hit_u, hit_v, hit_w, hit_vec;
	rt_pkg::vec_t rd_vec;

	assign acc = psel && penable; // Access phase, no wait states
	assign base = {paddr[7:4], 4'h0};
	assign comp = paddr[3:2];
	assign comp_ok = (paddr[1:0] == 2'b00) && (comp != 2'd3);

	assign hit_ctrl = (paddr == `RT_ADDR_CTRL);
	assign hit_e = (base == `RT_ADDR_E);
	assign hit_u = (base == `RT_ADDR_U);
	assign hit_v = (base == `RT_ADDR_V);
	assign hit_w = (base == `RT_ADDR_W);
	assign hit_vec = comp_ok && (hit_e || hit_u || hit_v || hit_w);
	assign mapped = hit_ctrl || hit_vec;

	assign pready = 1'b1;
	assign pslverr = acc && !mapped;
	assign wr_ok = acc && pwrite && mapped;

	always_comb begin
		rd_vec = cam.e;
		if (hit_u) rd_vec = cam.u;
		if (hit_v) rd_vec = cam.v;
		if (hit_w) rd_vec = cam.w;
		prdata = '0;
		if (hit_ctrl) prdata = {31'b0, busy};
		else if (hit_vec) prdata = 32'(get_comp(rd_vec, comp));
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			cam <= '0;
			start <= 1'b0;
		end else begin
			start <= wr_ok && hit_ctrl && pwdata[0] && !busy; // Dropped while a frame runs
			if (wr_ok && hit_vec) begin
				if (hit_e) cam.e <= set_comp(cam.e, comp, pwdata[`RT_VW-1:0]);
				if (hit_u) cam.u <= set_comp(cam.u, comp, pwdata[`RT_VW-1:0]);
				if (hit_v) cam.v <= set_comp(cam.v, comp, pwdata[`RT_VW-1:0]);
				if (hit_w) cam.w <= set_comp(cam.w, comp, pwdata[`RT_VW-1:0]);
			end
		end
	end

endmodule

// File: pixel_scan.sv
`timescale 1ns/1ns
`include "rt_consts.svh"

module pixel_scan (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [3:0] fifo_count,
	input logic [1:0] in_flight,
	output logic busy,
	output logic issue_valid,
	output rt_pkg::pix_t issue
);

	typedef enum logic {IDLE, ACTIVE} state_t;

	state_t state;
	logic [4:0] used;
	logic last_col, last_pix;

	// Slots already claimed in the FIFO, counting rays still in the pipe
	assign used = 5'(fifo_count) + 5'(in_flight);

	assign busy = (state == ACTIVE);
	assign issue_valid = busy && (used < 5'(`RT_FIFO_DEPTH));

	assign last_col = (issue.x == rt_pkg::col_t'(`RT_COLS - 1));
	assign last_pix = (issue.id == rt_pkg::pixel_id_t'(`RT_NUM_RAYS - 1));

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= IDLE;
			issue <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (start) begin
						state <= ACTIVE;
						issue.x <= '0;
						issue.y <= rt_pkg::row_t'(`RT_ROWS - 1); // Top row first
						issue.id <= '0;
					end
				end
				ACTIVE: begin
					if (issue_valid) begin
						issue.id <= issue.id + 1'b1;
						if (last_col) begin
							issue.x <= '0;
							issue.y <= issue.y - 1'b1;
						end else begin
							issue.x <= issue.x + 1'b1;
						end
						if (last_pix) state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// File: ray_dir_pipe.sv
`timescale 1ns/1ns
`include "rt_consts.svh"

module ray_dir_pipe (
	input logic clk,
	input logic rst,
	input rt_pkg::cam_t cam,
	input logic issue_valid,
	input rt_pkg::pix_t issue,
	output logic out_valid,
	output rt_pkg::ray_t out,
	output logic [1:0] in_flight
);

	localparam int VW = `RT_VW;

	function automatic rt_pkg::vec_t vscale(logic signed [`RT_VW-1:0] s, rt_pkg::vec_t a);
		rt_pkg::vec_t r;
		r.x = s * a.x;
		r.y = s * a.y;
		r.z = s * a.z;
		return r;
	endfunction

	function automatic rt_pkg::vec_t vadd(rt_pkg::vec_t a, rt_pkg::vec_t b);
		rt_pkg::vec_t r;
		r.x = a.x + b.x;
		r.y = a.y + b.y;
		r.z = a.z + b.z;
		return r;
	endfunction

	logic signed [VW-1:0] sx, sy;

	logic v1, v2;
	rt_pkg::vec_t s1_pu, s1_pv, s1_e;
	rt_pkg::pixel_id_t s1_id;
	rt_pkg::vec_t s2_d, s2_e;
	rt_pkg::pixel_id_t s2_id;

	// Centred pixel offsets
	assign sx = VW'(issue.x) - VW'(`RT_COLS / 2);
	assign sy = VW'(issue.y) - VW'(`RT_ROWS / 2);

	assign in_flight = 2'(v1) + 2'(v2) + 2'(out_valid);

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			v1 <= issue_valid;
			v2 <= v1;
			out_valid <= v2;
		end
	end

	always_ff @(posedge clk) begin
		// Stage 1: sx*U and sy*V
		s1_pu <= vscale(sx, cam.u);
		s1_pv <= vscale(sy, cam.v);
		s1_e <= cam.e;
		s1_id <= issue.id;

		// Stage 2
		s2_d <= vadd(s1_pu, s1_pv);
		s2_e <= s1_e;
		s2_id <= s1_id;

		// Stage 3: add the view direction
		out.dir <= vadd(s2_d, cam.w);
		out.origin <= s2_e;
		out.id <= s2_id;
	end

endmodule

// File: ray_fifo.sv
`timescale 1ns/1ns
`include "rt_consts.svh"

module ray_fifo #(
	parameter int DEPTH = `RT_FIFO_DEPTH
) (
	input logic clk,
	input logic rst,
	input logic wr_valid,
	input rt_pkg::ray_t wr_data,
	output logic ray_valid,
	output rt_pkg::ray_t ray,
	input logic ray_stall,
	output logic [3:0] fifo_count
);

	localparam int AW = $clog2(DEPTH);

	rt_pkg::ray_t mem [DEPTH];
	logic [AW-1:0] wr_ptr, rd_ptr;
	logic [AW:0] count;
	logic push, pop, full;

	assign full = (count == (AW+1)'(DEPTH));
	assign push = wr_valid && !full; // Credit keeps this from ever blocking
	assign pop = ray_valid && !ray_stall;

	assign ray_valid = (count != '0);
	assign ray = mem[rd_ptr]; // Head stays put while stalled
	assign fifo_count = 4'(count);

	always_ff @(posedge clk) begin
		if (push) mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: prg_top.sv
`timescale 1ns/1ns

module prg_top (
	input logic clk,
	input logic rst,
	input logic [7:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic ray_valid,
	output rt_pkg::ray_t ray,
	input logic ray_stall
);

	rt_pkg::cam_t cam;
	logic start, busy;
	logic issue_valid;
	rt_pkg::pix_t issue;
	logic out_valid;
	rt_pkg::ray_t pipe_ray;
	logic [1:0] in_flight;
	logic [3:0] fifo_count;

	cam_regs regs0 (
		.clk(clk),
		.rst(rst),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.busy(busy),
		.cam(cam),
		.start(start)
	);

	pixel_scan scan0 (
		.clk(clk),
		.rst(rst),
		.start(start),
		.fifo_count(fifo_count),
		.in_flight(in_flight),
		.busy(busy),
		.issue_valid(issue_valid),
		.issue(issue)
	);

	ray_dir_pipe pipe0 (
		.clk(clk),
		.rst(rst),
		.cam(cam),
		.issue_valid(issue_valid),
		.issue(issue),
		.out_valid(out_valid),
		.out(pipe_ray),
		.in_flight(in_flight)
	);

	ray_fifo fifo0 (
		.clk(clk),
		.rst(rst),
		.wr_valid(out_valid),
		.wr_data(pipe_ray),
		.ray_valid(ray_valid),
		.ray(ray),
		.ray_stall(ray_stall),
		.fifo_count(fifo_count)
	);

endmodule

// File: tb_prg.sv
`timescale 1ns/1ns
`include "rt_consts.svh"

module tb_prg;

	localparam int RAY_WAIT = 200; // Cycles allowed for each ray
	localparam int APB_WAIT = 16;

	logic clk, rst;
	logic [7:0] paddr;
	logic psel, penable, pwrite;
	logic [31:0] pwdata, prdata;
	logic pready, pslverr;
	logic ray_valid, ray_stall;
	rt_pkg::ray_t ray;

	logic signed [`RT_VW-1:0] cam_m [4][3]; // E, U, V, W as last written
	int errors = 0;
	int tests_run = 0;
	int tests_bad = 0;

	prg_top dut0 (
		.clk(clk),
		.rst(rst),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.ray_valid(ray_valid),
		.ray(ray),
		.ray_stall(ray_stall)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
		assert (got === exp) else begin
			$display("FAILED %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	function automatic logic [7:0] reg_addr(int vi, int c);
		return 8'(`RT_ADDR_E + 16 * vi + 4 * c);
	endfunction

	// Expected ray for a pixel in scan order
	function automatic rt_pkg::ray_t model_ray(int id);
		rt_pkg::ray_t r;
		logic signed [`RT_VW-1:0] d [3];
		int sx, sy, c;
		sx = id % `RT_COLS - `RT_COLS / 2;
		sy = (`RT_ROWS - 1 - id / `RT_COLS) - `RT_ROWS / 2; // Top row first
		for (c = 0; c < 3; c++)
			d[c] = `RT_VW'(cam_m[3][c] + sx * cam_m[1][c] + sy * cam_m[2][c]);
		r.origin = {cam_m[0][0], cam_m[0][1], cam_m[0][2]};
		r.dir = {d[0], d[1], d[2]};
		r.id = rt_pkg::pixel_id_t'(id);
		return r;
	endfunction

	task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] data,
			output logic [31:0] rdata, output logic err);
		int n;
		paddr = addr;
		pwrite = wr;
		pwdata = data;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge clk);
		#2;
		penable = 1'b1;
		n = 0;
		@(negedge clk);
		while (!pready && n < APB_WAIT) begin
			@(negedge clk);
			n++;
		end
		assert (pready) else begin
			$display("APB access to address %h got no pready in %0d cycles", addr, APB_WAIT);
			errors++;
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		#2;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused;
		apb_access(addr, 1'b1, data, unused, err);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		apb_access(addr, 1'b0, 32'h0, data, err);
	endtask

	task automatic set_cam_reg(int vi, int c, logic [31:0] data);
		logic err;
		apb_write(reg_addr(vi, c), data, err);
		check_val("pslverr", err, 0);
		cam_m[vi][c] = data[`RT_VW-1:0]; // Upper bits are dropped
	endtask

	task automatic readback_all();
		logic [31:0] d;
		logic err;
		int vi, c;
		for (vi = 0; vi < 4; vi++) begin
			for (c = 0; c < 3; c++) begin
				apb_read(reg_addr(vi, c), d, err);
				check_val("prdata", d, {16'h0, cam_m[vi][c]});
				check_val("pslverr", err, 0);
			end
		end
	endtask

	task automatic start_frame();
		logic err;
		apb_write(`RT_ADDR_CTRL, 32'h1, err);
		check_val("pslverr", err, 0);
	endtask

	task automatic expect_busy(logic exp);
		logic [31:0] d;
		logic err;
		apb_read(`RT_ADDR_CTRL, d, err);
		check_val("busy", d, {31'h0, exp});
		check_val("pslverr", err, 0);
	endtask

	task automatic collect_frame(int stall_pct);
		rt_pkg::ray_t exp;
		int i, n;
		logic done;
		for (i = 0; i < `RT_NUM_RAYS; i++) begin
			exp = model_ray(i);
			done = 1'b0;
			n = 0;
			while (!done && n < RAY_WAIT) begin
				ray_stall = ($urandom % 100) < stall_pct;
				@(negedge clk);
				if (ray_valid && !ray_stall) begin // Taken on the next edge
					check_val("ray.id", ray.id, exp.id);
					check_val("ray.origin", ray.origin, exp.origin);
					check_val("ray.dir", ray.dir, exp.dir);
					done = 1'b1;
				end
				@(posedge clk);
				#2;
				n++;
			end
			assert (done) else begin
				$display("ray %0d did not arrive within %0d cycles", i, RAY_WAIT);
				errors++;
			end
			if (!done) break;
		end
		ray_stall = 1'b0;
	endtask

	task automatic expect_quiet(int cycles);
		int n;
		ray_stall = 1'b0;
		for (n = 0; n < cycles; n++) begin
			@(negedge clk);
			assert (!ray_valid) else begin
				$display("an extra ray with id %0d arrived after the frame", ray.id);
				errors++;
			end
			if (ray_valid) break;
			@(posedge clk);
			#2;
		end
	endtask

	task automatic end_test(string name, int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("%s: ok", name);
		end else begin
			tests_bad++;
			$display("%s: %0d errors", name, errors - errs_before);
		end
	endtask

	task automatic check_reset_state();
		int e0;
		e0 = errors;
		check_val("ray_valid", ray_valid, 0);
		check_val("pslverr", pslverr, 0);
		expect_busy(1'b0);
		end_test("reset_state", e0);
	endtask

	task automatic register_readback();
		logic [7:0] bad [4] = '{8'h50, 8'h2c, 8'h04, 8'h12}; // Outside the map
		logic [31:0] d;
		logic err;
		int e0, vi, c;
		e0 = errors;
		for (vi = 0; vi < 4; vi++)
			for (c = 0; c < 3; c++)
				set_cam_reg(vi, c, $urandom);
		readback_all();
		for (vi = 0; vi < 4; vi++) begin
			apb_write(bad[vi], 32'hffff_ffff, err);
			check_val("pslverr", err, 1);
		end
		apb_read(8'h50, d, err);
		check_val("pslverr", err, 1);
		readback_all();
		expect_busy(1'b0);
		end_test("register_readback", e0);
	endtask

	task automatic free_running_frame();
		int e0;
		e0 = errors;
		start_frame();
		collect_frame(0);
		expect_quiet(40);
		expect_busy(1'b0);
		end_test("free_running_frame", e0);
	endtask

	task automatic stalled_frame();
		int e0;
		e0 = errors;
		start_frame();
		collect_frame(50);
		expect_quiet(40);
		end_test("stalled_frame", e0);
	endtask

	task automatic restart_while_busy();
		int e0;
		e0 = errors;
		ray_stall = 1'b1; // Full FIFO holds the scan on credit
		start_frame();
		expect_busy(1'b1);
		start_frame();
		collect_frame(0);
		expect_quiet(40);
		expect_busy(1'b0);
		set_cam_reg(3, 0, $urandom);
		set_cam_reg(1, 1, $urandom);
		set_cam_reg(2, 2, $urandom);
		set_cam_reg(0, 0, $urandom);
		start_frame();
		collect_frame(30);
		expect_quiet(40);
		end_test("restart_while_busy", e0);
	endtask

	initial begin
		void'($urandom(32'h9a93));
		rst = 1'b1;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		ray_stall = 1'b0;
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;

		check_reset_state();
		register_readback();
		free_running_frame();
		stalled_frame();
		restart_while_busy();

		$display("tests run %0d, with errors %0d, check errors %0d", tests_run, tests_bad,
			errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: flist.f
+incdir+.
rt_pkg.sv
cam_regs.sv
pixel_scan.sv
ray_dir_pipe.sv
ray_fifo.sv
prg_top.sv
tb_prg.sv

// File: Makefile
SRCS = flist.f rt_consts.svh rt_pkg.sv cam_regs.sv pixel_scan.sv ray_dir_pipe.sv \
	ray_fifo.sv prg_top.sv tb_prg.sv

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_prg: $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_prg -f flist.f -Mdir obj_dir

sim.log: obj_dir/Vtb_prg
	./obj_dir/Vtb_prg > sim.log 2>&1 || true

run: obj_dir/Vtb_prg
	./obj_dir/Vtb_prg > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "tests failed" sim.log; then exit 1; fi
	@grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
